//--- Bender.yml
package:
  name: control_unit

export_include_dirs:
  - include

sources:
  # RTL in compile order
  - files:
      - hw/ctrlPkg.sv
      - hw/instrDecoder.sv
      - hw/stepSequencer.sv
      - hw/controlWordGen.sv
      - hw/controlUnit.sv
  # Testbench and bound properties
  - target: test
    files:
      - tb/controlUnit_props.sv
      - tb/controlUnitTb.sv

//--- hw/controlUnit.sv
// Top level of the multicycle control unit, from instruction register to datapath control word
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module controlUnit (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::instrWord_u instr,
    output ctrlPkg::ctrlWord_s ctrl
);

    ctrlPkg::instrClass_e iClass;
    ctrlPkg::seqState_s   state;

    // Pure combinational, sampled by the sequencer at the last decode step
    instrDecoder uDecoder (
        .instr  (instr),
        .iClass (iClass)
    );

    stepSequencer uSequencer (
        .clk    (clk),
        .rstN   (rstN),
        .iClass (iClass),
        .state  (state)
    );

    // ctrl trails state by one clock
    controlWordGen uWordGen (
        .clk   (clk),
        .rstN  (rstN),
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

//--- hw/controlWordGen.sv
// Control word table indexed by sequencer state, registered once before driving the datapath
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module controlWordGen (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::seqState_s state,
    output ctrlPkg::ctrlWord_s ctrl
);

    ctrlPkg::ctrlWord_s word;
    logic               isSub;

    assign isSub = (state.iClass == ctrlPkg::classSub);

    always_comb begin
        // Anything not set below stays zero
        word = '0;

        case (state.phase)
            ctrlPkg::phReset: begin
                // Load the stack pointer with its initial value
                word.regWrite = 1'b1;
                word.wrReg    = `WRREG_SP;
                word.wdReg    = `WDREG_SP_INIT;
            end
            ctrlPkg::phFetch: begin
                if (state.step < `STEP_WIDTH'(`FETCH_READ_STEPS)) begin
                    // Memory read at PC while the ALU computes PC + 4
                    word.memRead = 1'b1;
                    word.aluSrcA = `SRCA_PC;
                    word.aluSrcB = `SRCB_FOUR;
                    word.aluOp   = `ALUOP_ADD;
                end else begin
                    // PC + 4 goes back through pcSource 00
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                end
            end
            ctrlPkg::phDecode: begin
                if (state.step == `STEP_WIDTH'(0)) begin
                    // Branch target precomputed into ALUOut
                    word.aluOutLoad = 1'b1;
                    word.aluSrcA    = `SRCA_PC;
                    word.aluSrcB    = `SRCB_IMM_SHIFTED;
                    word.aluOp      = `ALUOP_ADD;
                end else begin
                    word.loadAB = 1'b1;
                end
            end
            ctrlPkg::phExec: begin
                case (state.step)
                    `STEP_WIDTH'(0): begin
                        word.aluOutLoad = 1'b1;
                        word.aluSrcA    = `SRCA_REGA;
                        word.aluSrcB    = isSub ? `SRCB_REGB : `SRCB_IMM;
                        word.aluOp      = isSub ? `ALUOP_SUB : `ALUOP_ADD;
                    end
                    `STEP_WIDTH'(1): begin
                        // R-type writes rd, immediates write rt
                        word.regWrite = 1'b1;
                        word.wdReg    = `WDREG_ALUOUT;
                        word.wrReg    = isSub ? `WRREG_RD : `WRREG_RT;
                    end
                    default: begin
                        word = '0;
                    end
                endcase
            end
            default: begin
                // Error step and unused phase codes issue nothing
                word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl <= '0;
        end else begin
            ctrl <= word;
        end
    end

endmodule

//--- hw/ctrlPkg.sv
// Types shared by the control unit modules, referenced by scoped name from each of them
`include "ctrl_macros.svh"

package ctrlPkg;

    // R-type view of the instruction word
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields_s;

    // I-type view of the instruction word
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeFields_s;

    // Same 32 bits, two decodings
    typedef union packed {
        rTypeFields_s rType;
        iTypeFields_s iType;
    } instrWord_u;

    typedef enum logic [1:0] {
        classSub,
        classAddi,
        classAddiu,
        classIllegal
    } instrClass_e;

    typedef enum logic [2:0] {
        phReset,
        phFetch,
        phDecode,
        phExec,
        phError
    } phase_e;

    typedef struct packed {
        phase_e                  phase;
        logic [`STEP_WIDTH-1:0]  step;
        instrClass_e             iClass;   // latched at the last decode step
    } seqState_s;

    // Datapath control word, one strobe or select per field
    typedef struct packed {
        logic       pcWrite;
        logic       loadAB;
        logic       aluOutLoad;
        logic       memRead;
        logic       irWrite;
        logic       regWrite;
        logic [2:0] aluOp;
        logic [1:0] iorD;
        logic [1:0] wrReg;
        logic [2:0] wdReg;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] pcSource;
    } ctrlWord_s;

endpackage

//--- hw/instrDecoder.sv
// Combinational classifier that maps the instruction register contents to an instruction class
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module instrDecoder (
    input  ctrlPkg::instrWord_u  instr,
    output ctrlPkg::instrClass_e iClass
);

    logic [5:0] opcode;
    logic [5:0] funct;

    // Opcode sits in the same bits for both views
    assign opcode = instr.iType.opcode;

    // Only meaningful when the opcode says R-type
    assign funct = instr.rType.funct;

    always_comb begin
        case (opcode)
            `OP_RTYPE: begin
                if (funct == `FUNCT_SUB) begin
                    iClass = ctrlPkg::classSub;
                end else begin
                    // AND, ADD, shifts, MULT, DIV and the rest are not implemented
                    iClass = ctrlPkg::classIllegal;
                end
            end
            `OP_ADDI: begin
                iClass = ctrlPkg::classAddi;
            end
            `OP_ADDIU: begin
                iClass = ctrlPkg::classAddiu;
            end
            default: begin
                // Loads, stores, branches, jumps and unknown opcodes
                iClass = ctrlPkg::classIllegal;
            end
        endcase
    end

endmodule

//--- hw/stepSequencer.sv
// Phase and step sequencer that walks reset, fetch, decode, execute and error steps
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module stepSequencer (
    input  logic                 clk,
    input  logic                 rstN,
    input  ctrlPkg::instrClass_e iClass,
    output ctrlPkg::seqState_s   state
);

    ctrlPkg::seqState_s nextState;

    // Last step index of each phase
    logic fetchDone;
    logic decodeDone;
    logic execDone;

    assign fetchDone  = (state.step == `STEP_WIDTH'(`FETCH_READ_STEPS));
    assign decodeDone = (state.step == `STEP_WIDTH'(1));
    assign execDone   = (state.step == `STEP_WIDTH'(2));

    always_comb begin
        nextState      = state;
        nextState.step = state.step + `STEP_WIDTH'(1);

        case (state.phase)
            ctrlPkg::phReset: begin
                nextState.phase = ctrlPkg::phFetch;
                nextState.step  = '0;
            end
            ctrlPkg::phFetch: begin
                if (fetchDone) begin
                    nextState.phase = ctrlPkg::phDecode;
                    nextState.step  = '0;
                end
            end
            ctrlPkg::phDecode: begin
                if (decodeDone) begin
                    // IR has been stable since the cycle after irWrite
                    nextState.iClass = iClass;
                    nextState.step   = '0;
                    if (iClass == ctrlPkg::classIllegal) begin
                        nextState.phase = ctrlPkg::phError;
                    end else begin
                        nextState.phase = ctrlPkg::phExec;
                    end
                end
            end
            ctrlPkg::phExec: begin
                if (execDone) begin
                    nextState.phase = ctrlPkg::phFetch;
                    nextState.step  = '0;
                end
            end
            ctrlPkg::phError: begin
                // Single step, then straight back to fetch
                nextState.phase = ctrlPkg::phFetch;
                nextState.step  = '0;
            end
            default: begin
                nextState.phase = ctrlPkg::phFetch;
                nextState.step  = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state.phase  <= ctrlPkg::phReset;
            state.step   <= '0;
            state.iClass <= ctrlPkg::classIllegal;
        end else begin
            state <= nextState;
        end
    end

endmodule

//--- include/ctrl_macros.svh
// Encodings and step counts of the multicycle control unit, included by the RTL and testbench
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Opcodes
`define OP_RTYPE            6'b000000
`define OP_ADDI             6'b001000
`define OP_ADDIU            6'b001001

// R-type funct codes
`define FUNCT_SUB           6'b100010

// ALU operations
`define ALUOP_ADD           3'b001
`define ALUOP_SUB           3'b010

// ALU operand A mux
`define SRCA_PC             2'b00
`define SRCA_REGA           2'b10

// ALU operand B mux
`define SRCB_REGB           2'b00
`define SRCB_FOUR           2'b01
`define SRCB_IMM            2'b10
`define SRCB_IMM_SHIFTED    2'b11

// Register file write address mux
`define WRREG_RT            2'b00
`define WRREG_RD            2'b01
`define WRREG_SP            2'b11

// Register file write data mux
`define WDREG_ALUOUT        3'b000
`define WDREG_SP_INIT       3'b110

// Memory latency seen by fetch, in cycles
`define FETCH_READ_STEPS    3

// Step counter width, enough for the longest phase
`define STEP_WIDTH          2

`endif

//--- project.f
+incdir+include
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/stepSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
tb/controlUnit_props.sv
tb/controlUnitTb.sv

//--- tb/controlUnitTb.sv
// Self-checking testbench that runs random instructions through the control unit and reports
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module controlUnitTb;

    localparam int CLK_PERIOD       = 100;
    localparam int DRIVE_DELAY      = 5;
    localparam int RESET_CYCLES     = 5;
    localparam int NUM_INSTR        = 60;
    localparam int MAX_INSTR_CYCLES = 9;
    localparam int SLACK_CYCLES     = 20;
    localparam int WATCHDOG_NS      =
        (NUM_INSTR * MAX_INSTR_CYCLES + SLACK_CYCLES) * CLK_PERIOD;

    // Recognized by MIPS but not implemented by this unit
    localparam logic [5:0] OP_LW     = 6'b100011;
    localparam logic [5:0] OP_BEQ    = 6'b000100;
    localparam logic [5:0] FUNCT_AND = 6'b100100;

    logic                clk = 1'b0;
    logic                rstN;
    ctrlPkg::instrWord_u instr;
    ctrlPkg::ctrlWord_s  ctrl;

    integer seed;
    int     testErrors;
    int     passCount;
    int     failCount;

    controlUnit u_dut (
        .clk   (clk),
        .rstN  (rstN),
        .instr (instr),
        .ctrl  (ctrl)
    );

    bind controlUnit controlUnitProps uProps (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic nextCycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // Expected word per step name, straight from the step schedule
    function automatic ctrlPkg::ctrlWord_s expectedWord(input string stepName,
                                                        input logic isSub);
        ctrlPkg::ctrlWord_s w;
        w = '0;
        case (stepName)
            "stack init": begin
                w.regWrite = 1'b1;
                w.wrReg    = `WRREG_SP;
                w.wdReg    = `WDREG_SP_INIT;
            end
            "fetch read": begin
                w.memRead = 1'b1;
                w.aluSrcA = `SRCA_PC;
                w.aluSrcB = `SRCB_FOUR;
                w.aluOp   = `ALUOP_ADD;
            end
            "fetch load": begin
                w.pcWrite = 1'b1;
                w.irWrite = 1'b1;
            end
            "decode target": begin
                w.aluOutLoad = 1'b1;
                w.aluSrcA    = `SRCA_PC;
                w.aluSrcB    = `SRCB_IMM_SHIFTED;
                w.aluOp      = `ALUOP_ADD;
            end
            "decode load": begin
                w.loadAB = 1'b1;
            end
            "exec alu": begin
                w.aluOutLoad = 1'b1;
                w.aluSrcA    = `SRCA_REGA;
                w.aluSrcB    = isSub ? `SRCB_REGB : `SRCB_IMM;
                w.aluOp      = isSub ? `ALUOP_SUB : `ALUOP_ADD;
            end
            "exec write": begin
                w.regWrite = 1'b1;
                w.wdReg    = `WDREG_ALUOUT;
                w.wrReg    = isSub ? `WRREG_RD : `WRREG_RT;
            end
            default: begin
                // Reset, exec idle and error steps
                w = '0;
            end
        endcase
        return w;
    endfunction

    task automatic checkField(input string stepName, input string fieldName,
                              input logic [2:0] got, input logic [2:0] exp);
        assert (got === exp) else begin
            testErrors++;
            $display("MISMATCH at %0t ns: %s step, %s is %0h, expected %0h",
                     $time, stepName, fieldName, got, exp);
        end
    endtask

    task automatic compareWord(input ctrlPkg::ctrlWord_s exp, input string stepName);
        checkField(stepName, "pcWrite", 3'(ctrl.pcWrite), 3'(exp.pcWrite));
        checkField(stepName, "loadAB", 3'(ctrl.loadAB), 3'(exp.loadAB));
        checkField(stepName, "aluOutLoad", 3'(ctrl.aluOutLoad), 3'(exp.aluOutLoad));
        checkField(stepName, "memRead", 3'(ctrl.memRead), 3'(exp.memRead));
        checkField(stepName, "irWrite", 3'(ctrl.irWrite), 3'(exp.irWrite));
        checkField(stepName, "regWrite", 3'(ctrl.regWrite), 3'(exp.regWrite));
        checkField(stepName, "aluOp", ctrl.aluOp, exp.aluOp);
        checkField(stepName, "iorD", 3'(ctrl.iorD), 3'(exp.iorD));
        checkField(stepName, "wrReg", 3'(ctrl.wrReg), 3'(exp.wrReg));
        checkField(stepName, "wdReg", ctrl.wdReg, exp.wdReg);
        checkField(stepName, "aluSrcA", 3'(ctrl.aluSrcA), 3'(exp.aluSrcA));
        checkField(stepName, "aluSrcB", 3'(ctrl.aluSrcB), 3'(exp.aluSrcB));
        checkField(stepName, "pcSource", 3'(ctrl.pcSource), 3'(exp.pcSource));
    endtask

    task automatic expectStep(input string stepName, input logic isSub);
        nextCycle();
        compareWord(expectedWord(stepName, isSub), stepName);
    endtask

    task automatic finishTest(input string testName);
        if (testErrors == 0) begin
            passCount++;
            $display("PASS %s", testName);
        end else begin
            failCount++;
            $display("FAIL %s with %0d mismatches", testName, testErrors);
        end
        testErrors = 0;
    endtask

    function automatic void classify(input logic [31:0] word, output logic legal,
                                     output logic isSub);
        isSub = (word[31:26] == `OP_RTYPE) && (word[5:0] == `FUNCT_SUB);
        legal = isSub || (word[31:26] == `OP_ADDI) || (word[31:26] == `OP_ADDIU);
    endfunction

    task automatic pickInstruction(output logic [31:0] word, output string kind);
        logic [31:0] r;
        int          choice;
        r      = $random(seed);
        choice = $unsigned($random(seed)) % 6;
        case (choice)
            0: begin
                kind = "SUB";
                word = {`OP_RTYPE, r[25:11], 5'd0, `FUNCT_SUB};
            end
            1: begin
                kind = "ADDI";
                word = {`OP_ADDI, r[25:0]};
            end
            2: begin
                kind = "ADDIU";
                word = {`OP_ADDIU, r[25:0]};
            end
            3: begin
                kind = r[31] ? "LW" : "BEQ";
                word = {(r[31] ? OP_LW : OP_BEQ), r[25:0]};
            end
            4: begin
                kind = "AND";
                word = {`OP_RTYPE, r[25:11], 5'd0, FUNCT_AND};
            end
            default: begin
                kind = "random";
                word = r;
            end
        endcase
    endtask

    task automatic runInstruction(input int idx);
        logic [31:0] word;
        string       kind;
        logic        legal;
        logic        isSub;
        repeat (`FETCH_READ_STEPS) expectStep("fetch read", 1'b0);
        expectStep("fetch load", 1'b0);
        // Next instruction goes into the IR right after irWrite
        pickInstruction(word, kind);
        instr = word;
        classify(word, legal, isSub);
        expectStep("decode target", 1'b0);
        expectStep("decode load", 1'b0);
        if (legal) begin
            expectStep("exec alu", isSub);
            expectStep("exec write", isSub);
            expectStep("exec idle", isSub);
        end else begin
            expectStep("error step", 1'b0);
        end
        finishTest($sformatf("instruction %0d %s %08h", idx, kind, word));
    endtask

    initial begin
        seed       = 89848;
        rstN       = 1'b0;
        instr      = '0;
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
        repeat (RESET_CYCLES) expectStep("reset held", 1'b0);
        rstN = 1'b1;
        expectStep("stack init", 1'b0);
        finishTest("reset and stack init");
        for (int i = 0; i < NUM_INSTR; i++) begin
            runInstruction(i);
        end
        // Let the last pending properties complete
        repeat (2) nextCycle();
        $display("Tests %0d passed, %0d failed, property failures %0d",
                 passCount, failCount, u_dut.uProps.failureCount);
        if (failCount == 0 && u_dut.uProps.failureCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- tb/controlUnit_props.sv
// Concurrent timing checks on the control word, bound into controlUnit from the testbench
`timescale 1ns/1ns
`include "ctrl_macros.svh"

module controlUnitProps (
    input logic               clk,
    input logic               rstN,
    input ctrlPkg::ctrlWord_s ctrl
);

    int unsigned failureCount = 0;
    logic        spInit;
    logic        aluRegA;

    assign spInit  = ctrl.regWrite && (ctrl.wrReg == `WRREG_SP);
    assign aluRegA = ctrl.aluOutLoad && (ctrl.aluSrcA == `SRCA_REGA);

    resetClears: assert property (@(posedge clk) !rstN |=> (ctrl == '0))
        else begin
            failureCount++;
            $error("control word not cleared while reset is low");
        end

    // Exactly three read cycles per fetch
    readThreeCycles: assert property (@(posedge clk) disable iff (!rstN)
        $rose(ctrl.memRead) |-> ctrl.memRead ##1 ctrl.memRead ##1 ctrl.memRead ##1 !ctrl.memRead)
        else begin
            failureCount++;
            $error("memory read not held for exactly three cycles");
        end

    fetchThenDecode: assert property (@(posedge clk) disable iff (!rstN)
        $fell(ctrl.memRead) |-> (ctrl.pcWrite && ctrl.irWrite)
            ##1 (ctrl.aluOutLoad && (ctrl.aluSrcB == `SRCB_IMM_SHIFTED)) ##1 ctrl.loadAB)
        else begin
            failureCount++;
            $error("fetch end not followed by the two decode steps");
        end

    strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !spInit |-> $onehot0({ctrl.pcWrite, ctrl.loadAB, ctrl.aluOutLoad, ctrl.regWrite})
            && (!ctrl.irWrite || ctrl.pcWrite))
        else begin
            failureCount++;
            $error("more than one strobe high or irWrite without pcWrite");
        end

    // Supported instruction takes three execute steps
    execSequence: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.loadAB ##1 ctrl.aluOutLoad |-> (ctrl.aluSrcA == `SRCA_REGA)
            ##1 (ctrl.regWrite && (ctrl.wdReg == `WDREG_ALUOUT)) ##1 (ctrl == '0)
            ##1 ctrl.memRead)
        else begin
            failureCount++;
            $error("execute steps out of order after loadAB");
        end

    errorSequence: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.loadAB ##1 !ctrl.aluOutLoad |-> (ctrl == '0) ##1 ctrl.memRead)
        else begin
            failureCount++;
            $error("error step not a single empty cycle before fetch");
        end

    subOperands: assert property (@(posedge clk) disable iff (!rstN)
        aluRegA && (ctrl.aluOp == `ALUOP_SUB) |->
            (ctrl.aluSrcB == `SRCB_REGB) ##1 (ctrl.wrReg == `WRREG_RD))
        else begin
            failureCount++;
            $error("subtract step with wrong operand or write register");
        end

    addOperands: assert property (@(posedge clk) disable iff (!rstN)
        aluRegA && (ctrl.aluOp == `ALUOP_ADD) |->
            (ctrl.aluSrcB == `SRCB_IMM) ##1 (ctrl.wrReg == `WRREG_RT))
        else begin
            failureCount++;
            $error("add immediate step with wrong operand or write register");
        end

endmodule
